/* run_sim.sh */
#!/bin/sh
# Compile and run tb_fence_sync with Verilator from the project root.
set -u
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --top-module tb_fence_sync \
  -f tb.f -o tb_fence_sync_sim > "$BUILD_LOG" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_fence_sync_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Finished with errors" "$SIM_LOG"; then
  exit 1
fi
exit 0

/* source/cache_sync.sv */
// fence.i engine; copies every offered line, one at a time; requester must drop fence req on ack
`timescale 1ns/100ps
`default_nettype none

module cache_sync import sync_pkg::*; (
  input  wire                  clk,
  input  wire                  rst,
  // fence.i handshake
  input  wire                  i_fencei_req,
  output logic                 o_fencei_ack,
  // data-cache read side
  input  wire                  i_dcache_rpackreq,
  input  wire  [TAG_BITS-1:0]  i_dcache_retag,
  input  wire  [LINE_BITS-1:0] i_dcache_rdata,
  input  wire                  i_dcache_ack,
  output logic                 o_dcache_req,
  output logic                 o_dcache_rpackack,
  // instruction-cache write side
  input  wire                  i_icache_ack,
  output logic                 o_icache_req,
  output logic [TAG_BITS-1:0]  o_icache_wetag,
  output logic [LINE_BITS-1:0] o_icache_wdata
);

  sync_state_e state;

  // data-cache request held for the whole sync
  assign o_dcache_req = (state != SYNC_IDLE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state             <= SYNC_IDLE;
      o_fencei_ack      <= 1'b0;
      o_dcache_rpackack <= 1'b0;
      o_icache_req      <= 1'b0;
    end else begin
      // both acks are single-cycle pulses
      o_fencei_ack      <= 1'b0;
      o_dcache_rpackack <= 1'b0;
      case (state)
        SYNC_IDLE: begin
          // still-high req in the ack cycle is not a new fence
          if (i_fencei_req && !o_fencei_ack) begin
            state <= SYNC_READ;
          end
        end
        SYNC_READ: begin
          if (i_dcache_rpackreq) begin
            o_dcache_rpackack <= 1'b1;
            state             <= SYNC_WRITE;
          end else if (i_dcache_ack) begin
            // no lines left
            o_fencei_ack <= 1'b1;
            state        <= SYNC_IDLE;
          end
        end
        SYNC_WRITE: begin
          if (i_icache_ack) begin
            o_icache_req <= 1'b0;
            state        <= SYNC_READ;
          end else begin
            // raised the cycle after the line is latched
            o_icache_req <= 1'b1;
          end
        end
        default: state <= SYNC_IDLE;
      endcase
    end
  end

  // line latch, same edge as the rpackack
  always_ff @(posedge clk) begin
    if ((state == SYNC_READ) && i_dcache_rpackreq) begin
      o_icache_wetag <= i_dcache_retag;
      o_icache_wdata <= i_dcache_rdata;
    end
  end

  // scanner never offers a line in its done state
  a_ack_not_with_offer: assert property (@(posedge clk) disable iff (rst)
    !(i_dcache_ack && i_dcache_rpackreq));

  // exactly one bank answers, one cycle after the request
  a_bank_answers: assert property (@(posedge clk) disable iff (rst)
    $rose(o_icache_req) |=> i_icache_ack);

endmodule

`default_nettype wire

/* source/dcache_line_scanner.sv */
// stores must not overlap a sync; a store to a new tag zeroes the rest of the line, no write-back
`timescale 1ns/100ps
`default_nettype none

module dcache_line_scanner import sync_pkg::*; (
  input  wire                 clk,
  input  wire                 rst,
  // word store port
  input  wire                 i_st_valid,
  input  wire [ADDR_BITS-1:0] i_st_addr,
  input  wire [WORD_BITS-1:0] i_st_data,
  // sync side, request held by the engine
  input  wire                 i_sync_req,
  input  wire                 i_rpackack,
  output logic                o_rpackreq,
  output logic [TAG_BITS-1:0] o_retag,
  output logic [LINE_BITS-1:0] o_rdata,
  output logic                o_ack
);

  // line storage, payload without reset
  logic [TAG_BITS-1:0]    line_tag  [DC_LINES];
  logic [LINE_BITS-1:0]   line_data [DC_LINES];
  logic [DC_LINES-1:0]    line_valid;

  // store address split
  logic [TAG_BITS-1:0]      st_tag;
  logic [DC_IDX_BITS-1:0]   st_idx;
  logic [WORD_SEL_BITS-1:0] st_word;
  logic                     st_hit;
  logic [LINE_BITS-1:0]     fresh_line;

  // scan walk
  scan_state_e            scan_state;
  logic [DC_IDX_BITS-1:0] scan_ptr;
  logic                   scan_last;
  logic                   scan_step;

  assign st_tag  = i_st_addr[ADDR_BITS-1:LINE_OFS_BITS];
  assign st_idx  = st_tag[DC_IDX_BITS-1:0];
  assign st_word = i_st_addr[LINE_OFS_BITS-1 -: WORD_SEL_BITS];
  assign st_hit  = line_valid[st_idx] && (line_tag[st_idx] == st_tag);

  // replacement line: new word in place, others zero
  always_comb begin
    fresh_line = '0;
    fresh_line[st_word*WORD_BITS +: WORD_BITS] = i_st_data;
  end

  // tag and data arrays
  always_ff @(posedge clk) begin
    if (i_st_valid) begin
      if (st_hit) begin
        line_data[st_idx][st_word*WORD_BITS +: WORD_BITS] <= i_st_data;
      end else begin
        line_tag[st_idx]  <= st_tag;
        line_data[st_idx] <= fresh_line;
      end
    end
  end

  // valid bits only ever get set, nothing invalidates
  always_ff @(posedge clk) begin
    if (rst) begin
      line_valid <= '0;
    end else if (i_st_valid) begin
      line_valid[st_idx] <= 1'b1;
    end
  end

  assign scan_last = (scan_ptr == DC_IDX_BITS'(DC_LINES - 1));
  // skip an invalid line, or move on once the offered one is taken
  assign scan_step = !line_valid[scan_ptr] || i_rpackack;

  always_ff @(posedge clk) begin
    if (rst) begin
      scan_state <= SCAN_IDLE;
      scan_ptr   <= '0;
    end else begin
      case (scan_state)
        SCAN_IDLE: begin
          if (i_sync_req) begin
            scan_ptr   <= '0;
            scan_state <= SCAN_OFFER;
          end
        end
        SCAN_OFFER: begin
          if (scan_step) begin
            if (scan_last) begin
              scan_state <= SCAN_DONE;
            end else begin
              scan_ptr <= scan_ptr + 1'b1;
            end
          end
        end
        SCAN_DONE: begin
          // wait for the engine to release its request
          if (!i_sync_req) begin
            scan_state <= SCAN_IDLE;
          end
        end
        default: scan_state <= SCAN_IDLE;
      endcase
    end
  end

  // offer held stable until acked
  assign o_rpackreq = (scan_state == SCAN_OFFER) && line_valid[scan_ptr];
  assign o_retag    = line_tag[scan_ptr];
  assign o_rdata    = line_data[scan_ptr];
  assign o_ack      = (scan_state == SCAN_DONE) && i_sync_req;

  // a store in the middle of a walk could tear an offered line
  a_no_store_in_sync: assert property (@(posedge clk) disable iff (rst)
    i_sync_req |-> !i_st_valid);

  a_ack_needs_offer: assert property (@(posedge clk) disable iff (rst)
    i_rpackack |-> o_rpackreq);

endmodule

`default_nettype wire

/* source/fence_sync_top.sv */
// fence.i sync subsystem; no memory behind either cache, no stores while i_fencei_req is high
`timescale 1ns/100ps
`default_nettype none

module fence_sync_top import sync_pkg::*; (
  input  wire                  clk,
  input  wire                  rst,
  // store port
  input  wire                  i_st_valid,
  input  wire  [ADDR_BITS-1:0] i_st_addr,
  input  wire  [WORD_BITS-1:0] i_st_data,
  // fence port
  input  wire                  i_fencei_req,
  output logic                 o_fencei_ack,
  // fetch port
  input  wire                  i_fetch_valid,
  input  wire  [ADDR_BITS-1:0] i_fetch_addr,
  output logic                 o_fetch_hit,
  output logic [WORD_BITS-1:0] o_fetch_insn
);

  // scanner to engine
  logic                    sync_dcache_req;
  logic                    dcache_rpackreq;
  logic [TAG_BITS-1:0]     dcache_retag;
  logic [LINE_BITS-1:0]    dcache_rdata;
  logic                    dcache_rpackack;
  logic                    dcache_ack;

  // engine to banks, broadcast
  logic                    icache_req;
  logic [TAG_BITS-1:0]     icache_wetag;
  logic [LINE_BITS-1:0]    icache_wdata;
  logic                    icache_ack;
  logic [IC_BANKS-1:0]     bank_wr_ack;

  // banks to fetch path
  logic [IC_BANKS-1:0]           bank_hit;
  logic [IC_BANKS*LINE_BITS-1:0] bank_line;
  logic [IC_ENTRY_BITS-1:0]      rd_entry;
  logic [IC_TAG_BITS-1:0]        rd_tag;

  dcache_line_scanner dcache_line_scanner_inst (
    .clk        (clk),
    .rst        (rst),
    .i_st_valid (i_st_valid),
    .i_st_addr  (i_st_addr),
    .i_st_data  (i_st_data),
    .i_sync_req (sync_dcache_req),
    .i_rpackack (dcache_rpackack),
    .o_rpackreq (dcache_rpackreq),
    .o_retag    (dcache_retag),
    .o_rdata    (dcache_rdata),
    .o_ack      (dcache_ack)
  );

  cache_sync cache_sync_inst (
    .clk               (clk),
    .rst               (rst),
    .i_fencei_req      (i_fencei_req),
    .o_fencei_ack      (o_fencei_ack),
    .i_dcache_rpackreq (dcache_rpackreq),
    .i_dcache_retag    (dcache_retag),
    .i_dcache_rdata    (dcache_rdata),
    .i_dcache_ack      (dcache_ack),
    .o_dcache_req      (sync_dcache_req),
    .o_dcache_rpackack (dcache_rpackack),
    .i_icache_ack      (icache_ack),
    .o_icache_req      (icache_req),
    .o_icache_wetag    (icache_wetag),
    .o_icache_wdata    (icache_wdata)
  );

  // only the addressed bank acks, so OR is enough
  assign icache_ack = |bank_wr_ack;

  for (genvar g = 0; g < IC_BANKS; g++) begin : g_bank
    icache_bank #(
      .BANK_ID (g)
    ) icache_bank_inst (
      .clk        (clk),
      .rst        (rst),
      .i_wr_req   (icache_req),
      .i_wr_tag   (icache_wetag),
      .i_wr_data  (icache_wdata),
      .o_wr_ack   (bank_wr_ack[g]),
      .i_rd_entry (rd_entry),
      .i_rd_tag   (rd_tag),
      .o_rd_hit   (bank_hit[g]),
      .o_rd_line  (bank_line[g*LINE_BITS +: LINE_BITS])
    );
  end

  fetch_read_mux fetch_read_mux_inst (
    .clk           (clk),
    .rst           (rst),
    .i_fetch_valid (i_fetch_valid),
    .i_fetch_addr  (i_fetch_addr),
    .i_bank_hit    (bank_hit),
    .i_bank_line   (bank_line),
    .o_rd_entry    (rd_entry),
    .o_rd_tag      (rd_tag),
    .o_fetch_hit   (o_fetch_hit),
    .o_fetch_insn  (o_fetch_insn)
  );

endmodule

`default_nettype wire

/* source/fetch_read_mux.sv */
// fetch path with one cycle latency; hit is qualified by fetch valid, word only meaningful on hit
`timescale 1ns/100ps
`default_nettype none

module fetch_read_mux import sync_pkg::*; (
  input  wire                           clk,
  input  wire                           rst,
  input  wire                           i_fetch_valid,
  input  wire  [ADDR_BITS-1:0]          i_fetch_addr,
  // per-bank read results, bank 0 in the low slice
  input  wire  [IC_BANKS-1:0]           i_bank_hit,
  input  wire  [IC_BANKS*LINE_BITS-1:0] i_bank_line,
  output logic [IC_ENTRY_BITS-1:0]      o_rd_entry,
  output logic [IC_TAG_BITS-1:0]        o_rd_tag,
  output logic                          o_fetch_hit,
  output logic [WORD_BITS-1:0]          o_fetch_insn
);

  logic [TAG_BITS-1:0]      fetch_tag;
  logic [IC_BANK_BITS-1:0]  fetch_bank;
  logic [WORD_SEL_BITS-1:0] fetch_word;
  logic [LINE_BITS-1:0]     sel_line;

  // same split as the bank write side
  assign fetch_tag  = i_fetch_addr[ADDR_BITS-1:LINE_OFS_BITS];
  assign fetch_bank = fetch_tag[IC_BANK_BITS-1:0];
  assign fetch_word = i_fetch_addr[LINE_OFS_BITS-1 -: WORD_SEL_BITS];
  // every bank looks up the same entry
  assign o_rd_entry = fetch_tag[IC_ENTRY_LSB +: IC_ENTRY_BITS];
  assign o_rd_tag   = fetch_tag[TAG_BITS-1:IC_TAG_LSB];

  assign sel_line = i_bank_line[fetch_bank*LINE_BITS +: LINE_BITS];

  always_ff @(posedge clk) begin
    if (rst) begin
      o_fetch_hit <= 1'b0;
    end else begin
      o_fetch_hit <= i_fetch_valid && i_bank_hit[fetch_bank];
    end
  end

  // word pick
  always_ff @(posedge clk) begin
    o_fetch_insn <= sel_line[fetch_word*WORD_BITS +: WORD_BITS];
  end

endmodule

`default_nettype wire

/* source/icache_bank.sv */
// one icache bank; BANK_ID must be below IC_BANKS, reads are combinational, no invalidate
`timescale 1ns/100ps
`default_nettype none

module icache_bank import sync_pkg::*; #(
  parameter int BANK_ID = 0
) (
  input  wire                      clk,
  input  wire                      rst,
  // write port from the sync engine
  input  wire                      i_wr_req,
  input  wire  [TAG_BITS-1:0]      i_wr_tag,
  input  wire  [LINE_BITS-1:0]     i_wr_data,
  output logic                     o_wr_ack,
  // fetch read port
  input  wire  [IC_ENTRY_BITS-1:0] i_rd_entry,
  input  wire  [IC_TAG_BITS-1:0]   i_rd_tag,
  output logic                     o_rd_hit,
  output logic [LINE_BITS-1:0]     o_rd_line
);

  logic [IC_TAG_BITS-1:0] ent_tag  [IC_ENTRIES];
  logic [LINE_BITS-1:0]   ent_line [IC_ENTRIES];
  logic [IC_ENTRIES-1:0]  ent_valid;

  logic [IC_ENTRY_BITS-1:0] wr_entry;
  logic                     wr_take;

  assign wr_entry = i_wr_tag[IC_ENTRY_LSB +: IC_ENTRY_BITS];
  // own bank only; no second take while the ack is out
  assign wr_take  = i_wr_req && !o_wr_ack &&
                    (i_wr_tag[IC_BANK_BITS-1:0] == IC_BANK_BITS'(BANK_ID));

  always_ff @(posedge clk) begin
    if (wr_take) begin
      ent_tag[wr_entry]  <= i_wr_tag[TAG_BITS-1:IC_TAG_LSB];
      ent_line[wr_entry] <= i_wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ent_valid <= '0;
      o_wr_ack  <= 1'b0;
    end else begin
      o_wr_ack <= wr_take;
      if (wr_take) begin
        ent_valid[wr_entry] <= 1'b1;
      end
    end
  end

  // tag compare on the addressed entry
  assign o_rd_hit  = ent_valid[i_rd_entry] && (ent_tag[i_rd_entry] == i_rd_tag);
  assign o_rd_line = ent_line[i_rd_entry];

endmodule

`default_nettype wire

/* source/sync_pkg.sv */
// shared sizes for the fence.i sync path; 32-bit addresses, 16-byte lines, no byte enables
`default_nettype none

package sync_pkg;

  // address and line geometry
  localparam int ADDR_BITS     = 32;
  localparam int WORD_BITS     = 32;
  localparam int LINE_BITS     = 128;
  localparam int LINE_OFS_BITS = 4;
  // word select sits at address bits 3..2
  localparam int WORD_SEL_BITS = 2;
  // line address, bits 31..4
  localparam int TAG_BITS      = ADDR_BITS - LINE_OFS_BITS;

  // data cache, indexed by the low tag bits
  localparam int DC_LINES    = 8;
  localparam int DC_IDX_BITS = $clog2(DC_LINES);

  // instruction cache: tag[1:0] picks the bank, tag[3:2] the entry
  localparam int IC_BANKS      = 4;
  localparam int IC_BANK_BITS  = $clog2(IC_BANKS);
  localparam int IC_ENTRIES    = 4;
  localparam int IC_ENTRY_BITS = $clog2(IC_ENTRIES);
  localparam int IC_ENTRY_LSB  = IC_BANK_BITS;
  localparam int IC_TAG_LSB    = IC_BANK_BITS + IC_ENTRY_BITS;
  // stored tag is tag[27:4]
  localparam int IC_TAG_BITS   = TAG_BITS - IC_TAG_LSB;

  // sync engine states
  typedef enum logic [1:0] {
    SYNC_IDLE  = 2'd0,
    SYNC_READ  = 2'd1,
    SYNC_WRITE = 2'd2
  } sync_state_e;

  // data-cache scanner states
  typedef enum logic [1:0] {
    SCAN_IDLE  = 2'd0,
    SCAN_OFFER = 2'd1,
    SCAN_DONE  = 2'd2
  } scan_state_e;

endpackage

`default_nettype wire

/* tb.f */
source/sync_pkg.sv
source/dcache_line_scanner.sv
source/cache_sync.sv
source/icache_bank.sv
source/fetch_read_mux.sv
source/fence_sync_top.sv
tb/tb_fence_sync.sv

/* tb/tb_fence_sync.sv */
// drives fence_sync_top from a step table; no store overlaps a fence, fetch word checked on hits only
`timescale 1ns/100ps
`default_nettype none

module tb_fence_sync import sync_pkg::*; ();

  localparam int OP_STORE      = 0;
  localparam int OP_FENCE      = 1;
  localparam int OP_FETCH      = 2;
  localparam int FENCE_TIMEOUT = 200;
  // model icache is one flat array indexed by tag[3:0]
  localparam int IC_IDX_BITS   = IC_BANK_BITS + IC_ENTRY_BITS;
  localparam int IC_LINES      = IC_BANKS * IC_ENTRIES;

  logic        clk;
  logic        rst;
  logic        i_st_valid;
  logic [31:0] i_st_addr;
  logic [31:0] i_st_data;
  logic        i_fencei_req;
  logic        o_fencei_ack;
  logic        i_fetch_valid;
  logic [31:0] i_fetch_addr;
  logic        o_fetch_hit;
  logic [31:0] o_fetch_insn;

  // step table
  string       step_name [$];
  int          step_op   [$];
  logic [31:0] step_addr [$];
  logic        step_hit  [$];

  // reference model state
  logic [TAG_BITS-1:0]  m_dc_tag   [DC_LINES];
  logic [LINE_BITS-1:0] m_dc_line  [DC_LINES];
  logic                 m_dc_valid [DC_LINES];
  logic [TAG_BITS-1:0]  m_ic_tag   [IC_LINES];
  logic [LINE_BITS-1:0] m_ic_line  [IC_LINES];
  logic                 m_ic_valid [IC_LINES];

  int   seed;
  int   err_count;
  int   check_count;
  logic timed_out;

  fence_sync_top fence_sync_top_inst (
    .clk           (clk),
    .rst           (rst),
    .i_st_valid    (i_st_valid),
    .i_st_addr     (i_st_addr),
    .i_st_data     (i_st_data),
    .i_fencei_req  (i_fencei_req),
    .o_fencei_ack  (o_fencei_ack),
    .i_fetch_valid (i_fetch_valid),
    .i_fetch_addr  (i_fetch_addr),
    .o_fetch_hit   (o_fetch_hit),
    .o_fetch_insn  (o_fetch_insn)
  );

  // 20 ns clock
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic add_step(input string name, input int op, input logic [31:0] addr,
                          input logic hit);
    step_name.push_back(name);
    step_op.push_back(op);
    step_addr.push_back(addr);
    step_hit.push_back(hit);
  endtask

  // new tag wipes the line, then the word lands
  task automatic model_store(input logic [31:0] addr, input logic [31:0] data);
    logic [TAG_BITS-1:0]    tag;
    logic [DC_IDX_BITS-1:0] idx;
    int                     w;
    tag = addr[31:4];
    idx = tag[DC_IDX_BITS-1:0];
    w   = int'(addr[3:2]);
    if (!(m_dc_valid[idx] && (m_dc_tag[idx] == tag))) begin
      m_dc_tag[idx]  = tag;
      m_dc_line[idx] = '0;
    end
    m_dc_line[idx][w*WORD_BITS +: WORD_BITS] = data;
    m_dc_valid[idx] = 1'b1;
  endtask

  // every valid dcache line copied over
  task automatic model_fence();
    logic [IC_IDX_BITS-1:0] j;
    for (int i = 0; i < DC_LINES; i++) begin
      if (m_dc_valid[i]) begin
        j = m_dc_tag[i][IC_IDX_BITS-1:0];
        m_ic_tag[j]   = m_dc_tag[i];
        m_ic_line[j]  = m_dc_line[i];
        m_ic_valid[j] = 1'b1;
      end
    end
  endtask

  task automatic apply_store(input logic [31:0] addr, input logic [31:0] data);
    i_st_valid = 1'b1;
    i_st_addr  = addr;
    i_st_data  = data;
    @(posedge clk);
    #1;
    i_st_valid = 1'b0;
  endtask

  // hold req until the ack pulse, drop it right away
  task automatic apply_fence(input string name);
    int cycles;
    cycles       = 0;
    i_fencei_req = 1'b1;
    @(posedge clk);
    #1;
    while (!o_fencei_ack && (cycles < FENCE_TIMEOUT)) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    i_fencei_req = 1'b0;
    check_count++;
    assert (o_fencei_ack) else begin
      $display("fence %s got no acknowledge within %0d cycles", name, FENCE_TIMEOUT);
      err_count++;
      timed_out = 1'b1;
    end
    model_fence();
  endtask

  // one cycle latency, results read 1 ns after the edge
  task automatic apply_fetch(input string name, input logic [31:0] addr, input logic exp_hit);
    logic [TAG_BITS-1:0]    tag;
    logic [IC_IDX_BITS-1:0] idx;
    logic                   model_hit;
    logic [31:0]            exp_word;
    int                     w;
    tag       = addr[31:4];
    idx       = tag[IC_IDX_BITS-1:0];
    w         = int'(addr[3:2]);
    model_hit = m_ic_valid[idx] && (m_ic_tag[idx] == tag);
    exp_word  = m_ic_line[idx][w*WORD_BITS +: WORD_BITS];
    i_fetch_valid = 1'b1;
    i_fetch_addr  = addr;
    @(posedge clk);
    #1;
    i_fetch_valid = 1'b0;
    check_count++;
    assert (model_hit == exp_hit) else begin
      $display("reference model and step table disagree on the hit for %s", name);
      err_count++;
    end
    assert (o_fetch_hit === exp_hit) else begin
      $display("mismatch %s hit expected %0b actual %0b", name, exp_hit, o_fetch_hit);
      err_count++;
    end
    if (exp_hit) begin
      assert (o_fetch_insn === exp_word) else begin
        $display("mismatch %s insn expected %h actual %h", name, exp_word, o_fetch_insn);
        err_count++;
      end
    end
  endtask

  initial begin
    int          i;
    logic [31:0] data;
    rst           = 1'b1;
    i_st_valid    = 1'b0;
    i_st_addr     = '0;
    i_st_data     = '0;
    i_fencei_req  = 1'b0;
    i_fetch_valid = 1'b0;
    i_fetch_addr  = '0;
    seed          = 73614;
    err_count     = 0;
    check_count   = 0;
    timed_out     = 1'b0;
    for (int k = 0; k < DC_LINES; k++) begin
      m_dc_tag[k]   = '0;
      m_dc_line[k]  = '0;
      m_dc_valid[k] = 1'b0;
    end
    for (int k = 0; k < IC_LINES; k++) begin
      m_ic_tag[k]   = '0;
      m_ic_line[k]  = '0;
      m_ic_valid[k] = 1'b0;
    end

    // empty fence, then miss before any sync
    add_step("fence_empty", OP_FENCE, 32'h0000_0000, 1'b0);
    add_step("st_a0", OP_STORE, 32'h0000_1000, 1'b0);
    add_step("fetch_a0_pre", OP_FETCH, 32'h0000_1000, 1'b0);
    // two lines, partly written
    add_step("st_a2", OP_STORE, 32'h0000_1008, 1'b0);
    add_step("st_b1", OP_STORE, 32'h0000_1014, 1'b0);
    add_step("st_b3", OP_STORE, 32'h0000_101C, 1'b0);
    add_step("fence_ab", OP_FENCE, 32'h0000_0000, 1'b0);
    add_step("fetch_a0", OP_FETCH, 32'h0000_1000, 1'b1);
    add_step("fetch_a1_zero", OP_FETCH, 32'h0000_1004, 1'b1);
    add_step("fetch_a2", OP_FETCH, 32'h0000_1008, 1'b1);
    add_step("fetch_b0_zero", OP_FETCH, 32'h0000_1010, 1'b1);
    add_step("fetch_b1", OP_FETCH, 32'h0000_1014, 1'b1);
    add_step("fetch_b3", OP_FETCH, 32'h0000_101C, 1'b1);
    // new word hidden until the next fence
    add_step("st_a0_new", OP_STORE, 32'h0000_1000, 1'b0);
    add_step("fetch_a0_old", OP_FETCH, 32'h0000_1000, 1'b1);
    add_step("fence_2", OP_FENCE, 32'h0000_0000, 1'b0);
    add_step("fetch_a0_new", OP_FETCH, 32'h0000_1000, 1'b1);
    // tag 0x108 shares dcache index 0 with tag 0x100
    add_step("st_c0", OP_STORE, 32'h0000_1080, 1'b0);
    add_step("fence_3", OP_FENCE, 32'h0000_0000, 1'b0);
    add_step("fetch_c0", OP_FETCH, 32'h0000_1080, 1'b1);
    add_step("fetch_c1_zero", OP_FETCH, 32'h0000_1084, 1'b1);
    add_step("fetch_a0_kept", OP_FETCH, 32'h0000_1000, 1'b1);
    // tag 0x201 lands on the icache slot of 0x101
    add_step("st_d2", OP_STORE, 32'h0000_2018, 1'b0);
    add_step("fence_4", OP_FENCE, 32'h0000_0000, 1'b0);
    add_step("fetch_b1_gone", OP_FETCH, 32'h0000_1014, 1'b0);
    add_step("fetch_d2", OP_FETCH, 32'h0000_2018, 1'b1);
    add_step("fetch_d0_zero", OP_FETCH, 32'h0000_2010, 1'b1);

    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    check_count++;
    assert (!o_fencei_ack && !o_fetch_hit) else begin
      $display("fence ack or fetch hit is not low after reset");
      err_count++;
    end

    // a timed-out fence ends the walk
    i = 0;
    while ((i < step_name.size()) && !timed_out) begin
      case (step_op[i])
        OP_STORE: begin
          data = $random(seed);
          model_store(step_addr[i], data);
          apply_store(step_addr[i], data);
        end
        OP_FENCE: apply_fence(step_name[i]);
        default:  apply_fetch(step_name[i], step_addr[i], step_hit[i]);
      endcase
      i++;
    end

    $display("checks %0d, errors %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire
